// ==== build.f ====
logic/disp_pkg.sv
logic/disp_fifo_if.sv
logic/syncgen.sv
logic/disp_ctrl.sv
logic/disp_fifo.sv
logic/disp_out.sv
logic/disp_ip.sv
testbench/tb_disp_ip.sv

// ==== logic/disp_ctrl.sv ====
// One burst outstanding at most; a frame fetch armed at frame start begins once the FIFO clear ends
`timescale 1ns/100ps

module disp_ctrl
    import disp_pkg::*;
#(
    parameter int H_ACTIVE   = 640,
    parameter int V_ACTIVE   = 480,
    parameter int FIFO_DEPTH = 1024
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              disp_on,
    input  logic              frame_start,
    input  addr_t             disp_addr,
    input  logic              waitrequest,
    input  logic              readdatavalid,
    input  logic [DATA_W-1:0] readdata,
    output addr_t             address,
    output logic              read,
    disp_fifo_if.fetch        fifo
);

    localparam int FRAME_WORDS = H_ACTIVE * V_ACTIVE;
    localparam int REQ_W       = $clog2(FRAME_WORDS + BURST_LEN + 1);

    addr_t                        base_q;
    addr_t                        addr_q;
    logic [REQ_W-1:0]             req_cnt;
    logic [$clog2(BURST_LEN)-1:0] beat_cnt;
    logic                         wait_clr;
    logic                         run;
    logic                         busy;
    logic                         read_q;
    logic                         wr_q;
    logic                         room;
    logic                         issue;

    // Room for a full burst, counting the word still in the write register
    assign room  = (fifo.used <= FIFO_DEPTH - BURST_LEN) && !wr_q;
    assign issue = run && !fifo.clr && !busy && !read_q && room && (req_cnt < FRAME_WORDS);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_clr <= 1'b0;
            run      <= 1'b0;
            base_q   <= '0;
            addr_q   <= '0;
            req_cnt  <= '0;
            read_q   <= 1'b0;
        end else begin
            if (frame_start) begin
                base_q   <= disp_addr;
                wait_clr <= disp_on;  // No fetch at all for a frame started with display off
                run      <= 1'b0;
            end else if (wait_clr && fifo.clr && !read_q) begin
                wait_clr <= 1'b0;
                run      <= 1'b1;
                addr_q   <= base_q;
                req_cnt  <= '0;
            end
            if (issue) begin
                read_q <= 1'b1;
            end else if (read_q && !waitrequest) begin
                read_q  <= 1'b0;
                addr_q  <= addr_q + addr_t'(BURST_BYTES);
                req_cnt <= req_cnt + REQ_W'(BURST_LEN);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            beat_cnt <= '0;
        end else begin
            if (read_q && !waitrequest) begin
                busy <= 1'b1;
            end else if (readdatavalid && (beat_cnt == BURST_LEN - 1)) begin
                busy <= 1'b0;
            end
            if (readdatavalid) begin
                beat_cnt <= beat_cnt + 1'b1;  // Wraps back to zero after the last beat
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_q <= 1'b0;
        end else begin
            wr_q <= readdatavalid;
        end
    end

    always_ff @(posedge clk) begin
        if (readdatavalid) begin
            fifo.wdata <= pixel_t'(readdata[23:0]);
        end
    end

    assign fifo.wr = wr_q;
    assign address = addr_q;
    assign read    = read_q;

endmodule

// ==== logic/disp_fifo.sv ====
// FIFO_DEPTH must be a power of two; writes to a full FIFO and pops from an empty one are ignored
`timescale 1ns/100ps

module disp_fifo
    import disp_pkg::*;
#(
    parameter int FIFO_DEPTH = 1024
) (
    input  logic       clk,
    input  logic       arst_n,
    disp_fifo_if.store buf_port
);

    localparam int AW = $clog2(FIFO_DEPTH);

    pixel_t        mem [FIFO_DEPTH];
    logic [AW-1:0] wptr;
    logic [AW-1:0] rptr;
    logic [AW:0]   cnt;
    logic          do_wr;
    logic          do_rd;

    assign do_wr = buf_port.wr && (cnt != FIFO_DEPTH);
    assign do_rd = buf_port.rd && (cnt != 0);

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wptr] <= buf_port.wdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wptr <= '0;
            rptr <= '0;
            cnt  <= '0;
        end else if (buf_port.clr) begin
            wptr <= '0;  // Held empty for the whole clear
            rptr <= '0;
            cnt  <= '0;
        end else begin
            if (do_wr) begin
                wptr <= wptr + 1'b1;
            end
            if (do_rd) begin
                rptr <= rptr + 1'b1;
            end
            cnt <= cnt + do_wr - do_rd;
        end
    end

    assign buf_port.rdata = mem[rptr];  // Head word stays visible until popped
    assign buf_port.used  = cnt;
    assign buf_port.empty = (cnt == 0);

endmodule

// ==== logic/disp_fifo_if.sv ====
// FIFO_DEPTH must match the FIFO instance; clr holds the FIFO empty while high
`timescale 1ns/100ps

interface disp_fifo_if
    import disp_pkg::*;
#(
    parameter int FIFO_DEPTH = 1024
) ();

    logic                          wr;     // Write strobe from the fetch side
    pixel_t                        wdata;
    logic [$clog2(FIFO_DEPTH):0]   used;   // Fill count
    logic                          rd;     // Pop request from the output stage
    pixel_t                        rdata;  // Head word
    logic                          empty;
    logic                          clr;    // Frame alignment clear, high during vsync

    modport fetch (output wr, output wdata, input used, input clr);

    modport store (input wr, input wdata, input rd, input clr,
                   output used, output rdata, output empty);

    modport drain (output rd, input rdata, input empty);

endinterface

// ==== logic/disp_ip.sv ====
// Single clock design; vga_clk is clk/2 and read data must be 24-bit RGB in the low bits
`timescale 1ns/100ps

module disp_ip
    import disp_pkg::*;
#(
    parameter int H_ACTIVE   = 640,
    parameter int H_FRONT    = 16,
    parameter int H_SYNC     = 96,
    parameter int H_BACK     = 48,
    parameter int V_ACTIVE   = 480,
    parameter int V_FRONT    = 10,
    parameter int V_SYNC     = 2,
    parameter int V_BACK     = 33,
    parameter int FIFO_DEPTH = 1024
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              waitrequest,
    input  logic [DATA_W-1:0] readdata,
    input  logic              readdatavalid,
    output addr_t             address,
    output logic              read,
    output logic [4:0]        burstcount,
    output logic              vga_clk,
    output logic [7:0]        vga_r,
    output logic [7:0]        vga_g,
    output logic [7:0]        vga_b,
    output logic              vga_hs,
    output logic              vga_vs,
    output logic              vga_blank_n,
    input  addr_t             disp_addr,
    input  logic              disp_on,
    input  logic              clr_vblank,
    output logic              vblank
);

    logic pix_en;
    logic active;
    logic frame_start;

    disp_fifo_if #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_bus ();

    assign burstcount   = 5'(BURST_LEN);
    assign fifo_bus.clr = ~vga_vs;  // Realign the FIFO once per frame

    syncgen #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) i_syncgen (
        .clk         (clk),
        .arst_n      (arst_n),
        .clr_vblank  (clr_vblank),
        .pix_en      (pix_en),
        .vga_clk     (vga_clk),
        .hs          (vga_hs),
        .vs          (vga_vs),
        .active      (active),
        .frame_start (frame_start),
        .vblank      (vblank)
    );

    disp_ctrl #(
        .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .FIFO_DEPTH(FIFO_DEPTH)
    ) i_disp_ctrl (
        .clk           (clk),
        .arst_n        (arst_n),
        .disp_on       (disp_on),
        .frame_start   (frame_start),
        .disp_addr     (disp_addr),
        .waitrequest   (waitrequest),
        .readdatavalid (readdatavalid),
        .readdata      (readdata),
        .address       (address),
        .read          (read),
        .fifo          (fifo_bus.fetch)
    );

    disp_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_disp_fifo (
        .clk      (clk),
        .arst_n   (arst_n),
        .buf_port (fifo_bus.store)
    );

    disp_out i_disp_out (
        .clk         (clk),
        .arst_n      (arst_n),
        .pix_en      (pix_en),
        .active      (active),
        .disp_on     (disp_on),
        .fifo        (fifo_bus.drain),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_blank_n (vga_blank_n)
    );

endmodule

// ==== logic/disp_out.sv ====
// Colour and blank_n lag the active flag by one pixel; an empty FIFO shows as black
`timescale 1ns/100ps

module disp_out
    import disp_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       pix_en,
    input  logic       active,
    input  logic       disp_on,
    disp_fifo_if.drain fifo,
    output logic [7:0] vga_r,
    output logic [7:0] vga_g,
    output logic [7:0] vga_b,
    output logic       vga_blank_n
);

    pixel_t pix_q;
    logic   fetch;

    assign fetch   = pix_en && active && disp_on;
    assign fifo.rd = fetch;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pix_q       <= '0;
            vga_blank_n <= 1'b0;
        end else if (pix_en) begin
            vga_blank_n <= active;  // Blanking follows timing even with display off
            if (fetch && !fifo.empty) begin
                pix_q <= fifo.rdata;
            end else begin
                pix_q <= '0;
            end
        end
    end

    assign vga_r = pix_q.r;
    assign vga_g = pix_q.g;
    assign vga_b = pix_q.b;

endmodule

// ==== logic/disp_pkg.sv ====
// Assumes 32-bit Avalon read data with the pixel in bits 23:0 and fixed 16-beat bursts
package disp_pkg;

    localparam int DATA_W      = 32;  // Avalon read data width
    localparam int BURST_LEN   = 16;  // Words per burst
    localparam int BURST_BYTES = 64;  // Address step between bursts
    localparam int CNT_W       = 10;  // Sync counter width, enough for 1023 pixels or lines

    typedef logic [25:0] addr_t;      // Avalon byte address

    // One 24-bit RGB pixel as it sits in the low bits of a read word
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

endpackage

// ==== logic/syncgen.sv ====
// Pixel rate is clk/2; active region sits at count zero; hs and vs lag the counters by one pixel
`timescale 1ns/100ps

module syncgen
    import disp_pkg::*;
#(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic clk,
    input  logic arst_n,
    input  logic clr_vblank,
    output logic pix_en,
    output logic vga_clk,
    output logic hs,
    output logic vs,
    output logic active,
    output logic frame_start,
    output logic vblank
);

    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int HS_START = H_ACTIVE + H_FRONT;
    localparam int VS_START = V_ACTIVE + V_FRONT;

    logic             div_q;
    logic [CNT_W-1:0] hcnt;
    logic [CNT_W-1:0] vcnt;
    logic             line_end;
    logic             hs_area;
    logic             vs_area;
    logic             vs_d;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_q <= 1'b0;
        end else begin
            div_q <= ~div_q;
        end
    end

    assign pix_en  = div_q;
    assign vga_clk = ~div_q;  // Rises on the clk after each pixel enable

    assign line_end = (hcnt == H_TOTAL - 1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (pix_en) begin
            hcnt <= line_end ? '0 : hcnt + 1'b1;
            if (line_end) begin
                vcnt <= (vcnt == V_TOTAL - 1) ? '0 : vcnt + 1'b1;
            end
        end
    end

    assign hs_area = (hcnt >= HS_START) && (hcnt < HS_START + H_SYNC);
    assign vs_area = (vcnt >= VS_START) && (vcnt < VS_START + V_SYNC);
    assign active  = (hcnt < H_ACTIVE) && (vcnt < V_ACTIVE);

    // Sync pulses carry the same one-pixel delay as the colour path
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hs          <= 1'b1;
            vs          <= 1'b1;
            frame_start <= 1'b0;
        end else begin
            if (pix_en) begin
                hs <= ~hs_area;
                vs <= ~vs_area;
            end
            frame_start <= pix_en && line_end && (vcnt == V_ACTIVE - 1);  // Into front porch
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vs_d   <= 1'b1;
            vblank <= 1'b0;
        end else begin
            vs_d <= vs;
            if (vs_d && !vs) begin
                vblank <= 1'b1;  // Set has priority over a clear in the same cycle
            end else if (clr_vblank) begin
                vblank <= 1'b0;
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 -f build.f --top-module tb_disp_ip -o tb_disp_ip
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_disp_ip > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// ==== testbench/tb_disp_ip.sv ====
// Runs a 44x7 pixel frame; the memory model serves one burst at a time with random stalls and gaps
`timescale 1ns/100ps

module tb_disp_ip
    import disp_pkg::*;
();

    localparam int CLK_HALF     = 20;
    localparam int RESET_CYCLES = 10;
    localparam int H_TOT        = 44;
    localparam int V_TOT        = 7;
    localparam int FRAME_PIX    = H_TOT * V_TOT;
    localparam int ACT_PIX      = 32 * 4;
    localparam int WAIT_LIMIT   = 400;  // Pixels, more than one whole frame
    localparam int SIG_HS       = 0;
    localparam int SIG_VS       = 1;
    localparam int SIG_VBLANK   = 2;

    logic        clk;
    logic        arst_n;
    logic        waitrequest   = 1'b1;
    logic [31:0] readdata      = '0;
    logic        readdatavalid = 1'b0;
    addr_t       address;
    logic        read;
    logic [4:0]  burstcount;
    logic        vga_clk;
    logic [7:0]  vga_r;
    logic [7:0]  vga_g;
    logic [7:0]  vga_b;
    logic        vga_hs;
    logic        vga_vs;
    logic        vga_blank_n;
    addr_t       disp_addr;
    logic        disp_on;
    logic        clr_vblank;
    logic        vblank;

    int          err_cnt   = 0;
    int          pass_cnt  = 0;
    int          read_cnt  = 0;
    int          mem_state = 0;  // 0 idle, 1 stall, 2 latency, 3 beats
    int          stall_cnt = 0;
    int          lat_cnt   = 0;
    int          beat_idx  = 0;
    addr_t       burst_addr = '0;
    addr_t       burst_log[$];  // Every accepted burst address
    logic [31:0] rng = 32'hb7f9;

    disp_ip #(
        .H_ACTIVE(32), .H_FRONT(4), .H_SYNC(4), .H_BACK(4),
        .V_ACTIVE(4), .V_FRONT(1), .V_SYNC(1), .V_BACK(1)
    ) i_disp_ip (.*);

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Memory content is a function of the word index
    function automatic logic [31:0] pattern(input addr_t a);
        return xorshift({8'd0, a[25:2]});
    endfunction

    always @(negedge clk) begin
        if (arst_n !== 1'b1) begin
            mem_state     = 0;
            beat_idx      = 0;
            waitrequest   = 1'b1;
            readdatavalid = 1'b0;
        end else begin
            if (mem_state == 0 && read === 1'b1) begin
                rng       = xorshift(rng);
                stall_cnt = int'(rng[1:0]);
                lat_cnt   = 1 + int'(rng[3:2]);
                mem_state = 1;
            end
            if (mem_state == 1) begin
                if (stall_cnt == 0) begin
                    waitrequest = 1'b0;  // Accepted at the next rising edge
                    burst_addr  = address;
                    burst_log.push_back(address);
                    mem_state   = 2;
                end else begin
                    stall_cnt--;
                end
            end else if (mem_state == 2) begin
                waitrequest = 1'b1;
                lat_cnt--;
                if (lat_cnt == 0) begin
                    mem_state = 3;
                end
            end else if (mem_state == 3) begin
                rng = xorshift(rng);
                if (rng[2:0] == 3'd0) begin
                    readdatavalid = 1'b0;  // Gap between beats
                end else begin
                    readdatavalid = 1'b1;
                    readdata      = pattern(burst_addr + addr_t'(4 * beat_idx));
                    beat_idx++;
                    if (beat_idx == BURST_LEN) begin
                        beat_idx  = 0;
                        mem_state = 0;
                    end
                end
            end else begin
                readdatavalid = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (read === 1'b1) begin
            read_cnt++;
        end
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("[ERROR] %0t ns %s: expected %0h, got %0h", $time, name, want, got);
            err_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int start_err);
        if (err_cnt == start_err) begin
            $display("Test %s finished without errors", name);
        end else begin
            $display("Test %s finished with %0d errors", name, err_cnt - start_err);
        end
    endtask

    function automatic logic probe(input int which);
        case (which)
            SIG_HS:  return vga_hs;
            SIG_VS:  return vga_vs;
            default: return vblank;
        endcase
    endfunction

    // Returns at the falling clk edge right after the next pixel update
    task automatic pixel_step();
        int guard;
        guard = 0;
        @(negedge clk);
        while (vga_clk !== 1'b1 && guard < 4) begin
            @(negedge clk);
            guard++;
        end
        if (vga_clk !== 1'b1) begin
            $display("Timeout at %0t ns: vga_clk stopped toggling", $time);
            err_cnt++;
        end
    endtask

    task automatic wait_sig(input int which, input logic val, input int limit);
        int n;
        n = 0;
        pixel_step();
        while (probe(which) !== val && n < limit) begin
            pixel_step();
            n++;
        end
        if (probe(which) !== val) begin
            $display("Timeout at %0t ns: signal %0d never reached %0b", $time, which, val);
            err_cnt++;
        end
    endtask

    task automatic wait_edge(input int which, input logic val, input int limit);
        wait_sig(which, ~val, limit);
        wait_sig(which, val, limit);
    endtask

    task automatic check_idle_outputs();
        compare("read", 32'(read), 0);
        compare("vblank", 32'(vblank), 0);
        compare("rgb", 32'({vga_r, vga_g, vga_b}), 0);
        compare("vga_blank_n", 32'(vga_blank_n), 0);
        compare("vga_hs", 32'(vga_hs), 1);
        compare("vga_vs", 32'(vga_vs), 1);
    endtask

    // Pixel n of the frame holds the word at base + 4n
    task automatic check_pixels(input addr_t base, input int first, input int count);
        int          n;
        int          guard;
        logic [31:0] want;
        n     = 0;
        guard = 0;
        while (n < count && guard < 2 * WAIT_LIMIT) begin
            pixel_step();
            guard++;
            if (vga_blank_n === 1'b1) begin
                want = pattern(base + addr_t'(4 * (first + n)));
                compare("vga_r", 32'(vga_r), 32'(want[23:16]));
                compare("vga_g", 32'(vga_g), 32'(want[15:8]));
                compare("vga_b", 32'(vga_b), 32'(want[7:0]));
                n++;
            end
        end
        if (n < count) begin
            $display("Timeout at %0t ns: saw only %0d of %0d active pixels", $time, n, count);
            err_cnt++;
        end
    endtask

    // Arms a fetch at the next frame start and returns when that frame begins
    task automatic start_display(input addr_t base, output int log_start);
        disp_addr = base;
        disp_on   = 1'b1;
        wait_edge(SIG_VS, 1'b1, WAIT_LIMIT);
        wait_edge(SIG_VS, 1'b0, WAIT_LIMIT);
        log_start = burst_log.size();  // Fetch waits for the end of vsync
        wait_edge(SIG_VS, 1'b1, WAIT_LIMIT);
    endtask

    task automatic sync_timing_test();
        int   start_err;
        int   i;
        int   fall_idx;
        int   hs_falls;
        int   vs_low;
        int   blank_hi;
        logic prev_hs;
        start_err = err_cnt;
        wait_edge(SIG_VS, 1'b0, WAIT_LIMIT);
        fall_idx = -1;
        hs_falls = 0;
        vs_low   = 0;
        blank_hi = 0;
        prev_hs  = vga_hs;
        for (i = 0; i < FRAME_PIX; i++) begin
            if (i > 0) begin
                pixel_step();
            end
            if (prev_hs && !vga_hs) begin
                if (fall_idx >= 0) begin
                    compare("vga_hs period", i - fall_idx, H_TOT);
                end
                fall_idx = i;
                hs_falls++;
            end else if (!prev_hs && vga_hs && fall_idx >= 0) begin
                compare("vga_hs low width", i - fall_idx, 4);
            end
            prev_hs = vga_hs;
            vs_low   += int'(!vga_vs);
            blank_hi += int'(vga_blank_n);
            @(negedge clk);
            compare("vga_clk", 32'(vga_clk), 0);  // Second clk of the pixel
            compare("vga_hs", 32'(vga_hs), 32'(prev_hs));
        end
        compare("vga_hs pulses per frame", hs_falls, V_TOT);
        compare("vga_vs low pixels", vs_low, H_TOT);
        compare("vga_blank_n high pixels", blank_hi, ACT_PIX);
        report_test("sync timing", start_err);
    endtask

    task automatic frame_data_test(input addr_t base);
        int start_err;
        int log_start;
        int k;
        start_err = err_cnt;
        start_display(base, log_start);
        check_pixels(base, 0, ACT_PIX);
        compare("burst count", burst_log.size() - log_start, ACT_PIX / BURST_LEN);
        for (k = log_start; k < burst_log.size(); k++) begin
            compare("address", 32'(burst_log[k]),
                    32'(base + addr_t'(BURST_BYTES * (k - log_start))));
        end
        compare("burstcount", 32'(burstcount), 16);
        report_test("frame data", start_err);
    endtask

    task automatic display_off_test();
        int start_err;
        int i;
        int reads0;
        int blank_hi;
        int nonzero;
        start_err = err_cnt;
        disp_on   = 1'b0;
        wait_edge(SIG_VS, 1'b0, WAIT_LIMIT);
        wait_edge(SIG_VS, 1'b1, WAIT_LIMIT);
        reads0   = read_cnt;
        blank_hi = 0;
        nonzero  = 0;
        for (i = 0; i < FRAME_PIX; i++) begin
            pixel_step();
            blank_hi += int'(vga_blank_n);
            nonzero  += int'({vga_r, vga_g, vga_b} != 24'd0);
        end
        compare("read cycles", read_cnt - reads0, 0);
        compare("rgb non-black pixels", nonzero, 0);
        compare("vga_blank_n high pixels", blank_hi, ACT_PIX);
        report_test("display off", start_err);
    endtask

    task automatic pulse_clr();
        clr_vblank = 1'b1;
        @(negedge clk);
        clr_vblank = 1'b0;
        @(negedge clk);
    endtask

    task automatic vblank_test();
        int   start_err;
        int   n;
        int   stray;
        logic seen_high;
        start_err = err_cnt;
        pulse_clr();
        compare("vblank", 32'(vblank), 0);
        wait_edge(SIG_VS, 1'b0, WAIT_LIMIT);
        compare("vblank", 32'(vblank), 0);  // Set lands one clk after the vs edge
        wait_sig(SIG_VBLANK, 1'b1, 2);
        pulse_clr();
        compare("vblank", 32'(vblank), 0);
        n         = 0;
        stray     = 0;
        seen_high = 1'b0;
        while (!(seen_high && !vga_vs) && n < WAIT_LIMIT) begin
            pixel_step();
            seen_high |= vga_vs;
            stray     += int'(vblank);
            n++;
        end
        if (!(seen_high && !vga_vs)) begin
            $display("Timeout at %0t ns: no second vs falling edge", $time);
            err_cnt++;
        end
        compare("vblank high before vs edge", stray, 0);
        wait_sig(SIG_VBLANK, 1'b1, 2);
        report_test("vertical blank flag", start_err);
    endtask

    task automatic addr_change_test(input addr_t base_a, input addr_t base_b);
        int start_err;
        int log_start;
        start_err = err_cnt;
        start_display(base_a, log_start);
        check_pixels(base_a, 0, 8);
        disp_addr = base_b;  // Bursts of this frame are still in flight here
        check_pixels(base_a, 8, ACT_PIX - 8);
        wait_edge(SIG_VS, 1'b1, WAIT_LIMIT);
        check_pixels(base_b, 0, ACT_PIX);
        report_test("address change", start_err);
    endtask

    initial begin
        int start_err;
        arst_n     = 1'b0;
        disp_on    = 1'b0;
        disp_addr  = '0;
        clr_vblank = 1'b0;
        start_err  = err_cnt;
        repeat (RESET_CYCLES - 1) @(negedge clk);
        check_idle_outputs();
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_idle_outputs();
        report_test("reset state", start_err);

        sync_timing_test();
        frame_data_test(26'h010_0000);
        display_off_test();
        vblank_test();
        addr_change_test(26'h200_0000, 26'h3ff_f000);

        $display("Checks passed: %0d, errors: %0d", pass_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
